// ==== idma_noc_read_bridge.f ====
rtl/noc_pkg.sv
rtl/dma_pkg.sv
rtl/read_tag_if.sv
rtl/read_req_decoder.sv
rtl/read_tag_fifo.sv
rtl/read_return_seq.sv
rtl/idma_noc_read_bridge.sv
verif/tb_clk_gen.sv
verif/read_bridge_asserts.sv
verif/tb_idma_noc_read_bridge.sv

// ==== rtl/dma_pkg.sv ====
/*
 * iDMA side definitions
 * request widths and the beat to word conversion
 */
package dma_pkg;

  // beats of 256 bits per request
  typedef logic [12:0] beat_num_t;

  // offset counts 256-byte units
  localparam int ADDR_SHIFT = 8;

  // 256-bit beat holds 8 words of 32 bits
  localparam int WORD_SHIFT = 3;

  localparam int RD_NUM_W = 32;

endpackage

// ==== rtl/idma_noc_read_bridge.sv ====
/*
 * NoC to iDMA read bridge
 * decodes NoC read requests into iDMA reads and returns the data as NoC flits
 */
module idma_noc_read_bridge #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 256,
  parameter int TAG_DEPTH  = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,

  // base address config
  input  logic [ADDR_WIDTH-1:0]        base_addr_0,
  input  logic [ADDR_WIDTH-1:0]        base_addr_1,
  input  logic [ADDR_WIDTH-1:0]        base_addr_2,
  input  logic [ADDR_WIDTH-1:0]        base_addr_3,
  input  logic [ADDR_WIDTH-1:0]        base_addr_4,
  input  logic [ADDR_WIDTH-1:0]        base_addr_5,
  input  logic [ADDR_WIDTH-1:0]        group_base_addr_0,
  input  logic [ADDR_WIDTH-1:0]        group_base_addr_1,
  input  logic [ADDR_WIDTH-1:0]        group_base_addr_2,
  input  logic [ADDR_WIDTH-1:0]        group_base_addr_3,
  input  logic [ADDR_WIDTH-1:0]        group_base_addr_4,
  input  logic [ADDR_WIDTH-1:0]        group_base_addr_5,

  // NoC control channel in
  input  logic                         ctrl_in_valid,
  input  logic [noc_pkg::FLIT_W-1:0]   ctrl_in_flit,
  output logic                         ctrl_in_ready,

  // iDMA read
  output logic                         rd_req,
  output logic [ADDR_WIDTH-1:0]        rd_addr,
  output logic [dma_pkg::RD_NUM_W-1:0] rd_num,
  input  logic                         rd_addr_ready,
  input  logic                         rd_data_valid,
  input  logic [DATA_WIDTH-1:0]        rd_data,
  output logic                         rd_data_ready,

  // NoC data channel out
  output logic                         data_out_valid,
  output logic [DATA_WIDTH-1:0]        data_out_flit,
  output logic                         data_out_last,
  input  logic                         data_out_ready
);
  import noc_pkg::*;

  logic [ADDR_WIDTH-1:0] base_addr_arr       [NUM_SLOTS];
  logic [ADDR_WIDTH-1:0] group_base_addr_arr [NUM_SLOTS];

  assign base_addr_arr = '{base_addr_0, base_addr_1, base_addr_2,
                           base_addr_3, base_addr_4, base_addr_5};
  assign group_base_addr_arr = '{group_base_addr_0, group_base_addr_1, group_base_addr_2,
                                 group_base_addr_3, group_base_addr_4, group_base_addr_5};

  read_tag_if dec_tag ();
  read_tag_if seq_tag ();

  read_req_decoder #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_decoder (
    .clk             (clk),
    .rst_n           (rst_n),
    .base_addr       (base_addr_arr),
    .group_base_addr (group_base_addr_arr),
    .ctrl_in_valid   (ctrl_in_valid),
    .ctrl_in_flit    (ctrl_in_flit),
    .ctrl_in_ready   (ctrl_in_ready),
    .rd_req          (rd_req),
    .rd_addr         (rd_addr),
    .rd_num          (rd_num),
    .rd_addr_ready   (rd_addr_ready),
    .tag_out         (dec_tag.src)
  );

  read_tag_fifo #(
    .TAG_DEPTH (TAG_DEPTH)
  ) u_tag_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .tag_in  (dec_tag.dst),
    .tag_out (seq_tag.src)
  );

  read_return_seq #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_return_seq (
    .clk            (clk),
    .rst_n          (rst_n),
    .tag_in         (seq_tag.dst),
    .rd_data_valid  (rd_data_valid),
    .rd_data        (rd_data),
    .rd_data_ready  (rd_data_ready),
    .data_out_valid (data_out_valid),
    .data_out_flit  (data_out_flit),
    .data_out_last  (data_out_last),
    .data_out_ready (data_out_ready)
  );

endmodule

// ==== rtl/noc_pkg.sv ====
/*
 * NoC side definitions for the read bridge
 * flit field positions, mesh node ids, return header layout and FSM states
 */
package noc_pkg;

  localparam int FLIT_W = 256;

  // ============================
  // request flit fields
  // ============================
  localparam int NODE_ID_LSB   = 7;
  localparam int NODE_ID_MSB   = 10;
  localparam int TAG_LSB       = 7;
  localparam int TAG_MSB       = 18;
  localparam int RESP_FLAG_BIT = 5;
  localparam int OFFSET_LSB    = 19;
  localparam int OFFSET_MSB    = 43;
  localparam int NUM_LSB       = 69;
  localparam int NUM_MSB       = 81;
  // set selects the group base
  localparam int GROUP_SEL_BIT = 254;

  // ============================
  // node map
  // ============================
  // 4x4 mesh, row 0 at the bottom
  //   12 13 14 15
  //    8  9 10 11
  //    4  5  6  7
  //    0  1  2  3
  localparam int NUM_SLOTS = 6;

  typedef logic [3:0] node_id_t;

  localparam node_id_t left_ids  [NUM_SLOTS] = '{4'd0, 4'd1, 4'd4, 4'd5, 4'd8, 4'd9};
  localparam node_id_t right_ids [NUM_SLOTS] = '{4'd2, 4'd3, 4'd6, 4'd7, 4'd10, 4'd11};

  // ============================
  // return header
  // ============================
  typedef logic [11:0] tag_t;

  localparam int HDR_MARK_BIT = 12;
  localparam int HDR_FLAG_BIT = 13;

  typedef enum logic [1:0] {
    IDLE,
    SEND_HEAD,
    SEND_DATA
  } return_state_e;

endpackage

// ==== rtl/read_req_decoder.sv ====
/*
 * read request decoder
 * maps the requester node to a base address and registers the iDMA read request
 */
module read_req_decoder #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [ADDR_WIDTH-1:0]         base_addr       [noc_pkg::NUM_SLOTS],
  input  logic [ADDR_WIDTH-1:0]         group_base_addr [noc_pkg::NUM_SLOTS],
  input  logic                          ctrl_in_valid,
  input  logic [noc_pkg::FLIT_W-1:0]    ctrl_in_flit,
  output logic                          ctrl_in_ready,
  output logic                          rd_req,
  output logic [ADDR_WIDTH-1:0]         rd_addr,
  output logic [dma_pkg::RD_NUM_W-1:0]  rd_num,
  input  logic                          rd_addr_ready,
  read_tag_if.src                       tag_out
);
  import noc_pkg::*;
  import dma_pkg::*;

  node_id_t                   node_id;
  logic [OFFSET_MSB-OFFSET_LSB:0] offset;
  beat_num_t                  req_num;
  logic [ADDR_WIDTH-1:0]      slot_base;
  logic [ADDR_WIDTH-1:0]      slot_group_base;
  logic [ADDR_WIDTH-1:0]      req_addr;
  logic                       req_free;
  logic                       ctrl_in_hs;

  // ============================
  // field decode
  // ============================
  assign node_id = ctrl_in_flit[NODE_ID_MSB:NODE_ID_LSB];
  assign offset  = ctrl_in_flit[OFFSET_MSB:OFFSET_LSB];
  assign req_num = ctrl_in_flit[NUM_MSB:NUM_LSB];

  // unmapped nodes fall back to address 0
  always_comb begin
    slot_base       = '0;
    slot_group_base = '0;
    for (int k = 0; k < NUM_SLOTS; k++) begin
      if (node_id == left_ids[k] || node_id == right_ids[k]) begin
        slot_base       = base_addr[k];
        slot_group_base = group_base_addr[k];
      end
    end
  end

  // only the low ADDR_WIDTH-8 offset bits reach the address
  assign req_addr = (ctrl_in_flit[GROUP_SEL_BIT] ? slot_group_base : slot_base)
                  + (ADDR_WIDTH'(offset) << ADDR_SHIFT);

  // ============================
  // handshake
  // ============================
  // request stage free, or its content leaves this cycle
  assign req_free      = !rd_req || rd_addr_ready;
  assign ctrl_in_ready = tag_out.ready && req_free;
  assign ctrl_in_hs    = ctrl_in_valid && ctrl_in_ready;

  // tag goes to the buffer on the same edge as the request load
  assign tag_out.valid     = ctrl_in_valid && req_free;
  assign tag_out.tag       = ctrl_in_flit[TAG_MSB:TAG_LSB];
  assign tag_out.resp_flag = ctrl_in_flit[RESP_FLAG_BIT];
  assign tag_out.num       = req_num;

  // ============================
  // iDMA request register
  // ============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_req <= 1'b0;
    end else if (ctrl_in_hs) begin
      rd_req <= 1'b1;
    end else if (rd_addr_ready) begin
      rd_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_in_hs) begin
      rd_addr <= req_addr;
      // beats to 32-bit words
      rd_num  <= RD_NUM_W'(req_num) << WORD_SHIFT;
    end
  end

endmodule

// ==== rtl/read_return_seq.sv ====
/*
 * read return sequencer
 * sends the header flit, then the iDMA data beats, on the NoC data channel
 */
module read_return_seq #(
  parameter int DATA_WIDTH = 256
) (
  input  logic                  clk,
  input  logic                  rst_n,
  read_tag_if.dst               tag_in,
  input  logic                  rd_data_valid,
  input  logic [DATA_WIDTH-1:0] rd_data,
  output logic                  rd_data_ready,
  output logic                  data_out_valid,
  output logic [DATA_WIDTH-1:0] data_out_flit,
  output logic                  data_out_last,
  input  logic                  data_out_ready
);
  import noc_pkg::*;
  import dma_pkg::*;

  return_state_e         state;
  return_state_e         state_next;
  beat_num_t             num_q;
  beat_num_t             beat_cnt;
  logic                  out_free;
  logic                  pop;
  logic                  beat_hs;
  logic                  final_beat;
  logic [DATA_WIDTH-1:0] head_flit;

  // output register empty or draining this cycle
  assign out_free = !data_out_valid || data_out_ready;

  assign tag_in.ready  = (state == IDLE) && out_free;
  assign pop           = tag_in.valid && tag_in.ready;
  assign rd_data_ready = (state == SEND_DATA) && out_free;
  assign beat_hs       = rd_data_valid && rd_data_ready;
  assign final_beat    = (beat_cnt == beat_num_t'(num_q - 1'b1));

  always_comb begin
    head_flit                     = '0;
    head_flit[$bits(tag_t)-1:0]   = tag_in.tag;
    head_flit[HDR_MARK_BIT]       = 1'b1;
    head_flit[HDR_FLAG_BIT]       = tag_in.resp_flag;
  end

  // ============================
  // FSM
  // ============================
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (pop) begin
          state_next = SEND_HEAD;
        end
      end
      // wait for the header to leave
      SEND_HEAD: begin
        if (out_free) begin
          state_next = SEND_DATA;
        end
      end
      SEND_DATA: begin
        if (beat_hs && final_beat) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      num_q    <= '0;
      beat_cnt <= '0;
    end else begin
      state <= state_next;
      if (pop) begin
        num_q    <= tag_in.num;
        beat_cnt <= '0;
      end else if (beat_hs) begin
        beat_cnt <= final_beat ? '0 : beat_cnt + 1'b1;
      end
    end
  end

  // ============================
  // output flit register
  // ============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out_valid <= 1'b0;
      data_out_last  <= 1'b0;
    end else if (pop) begin
      data_out_valid <= 1'b1;
      data_out_last  <= 1'b0;
    end else if (beat_hs) begin
      data_out_valid <= 1'b1;
      data_out_last  <= final_beat;
    end else if (data_out_ready) begin
      data_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      data_out_flit <= head_flit;
    end else if (beat_hs) begin
      data_out_flit <= rd_data;
    end
  end

endmodule

// ==== rtl/read_tag_fifo.sv ====
/*
 * pending return tag queue
 * circular buffer, tags leave in arrival order
 */
module read_tag_fifo #(
  parameter int TAG_DEPTH = 16
) (
  input  logic    clk,
  input  logic    rst_n,
  read_tag_if.dst tag_in,
  read_tag_if.src tag_out
);
  import noc_pkg::*;
  import dma_pkg::*;

  localparam int PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
  localparam int CNT_W = $clog2(TAG_DEPTH + 1);

  tag_t       tag_mem  [TAG_DEPTH];
  logic       flag_mem [TAG_DEPTH];
  beat_num_t  num_mem  [TAG_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             not_full;
  logic             push;
  logic             pop;

  assign push = tag_in.valid && tag_in.ready;
  assign pop  = tag_out.valid && tag_out.ready;

  assign count_next = count + CNT_W'(push) - CNT_W'(pop);

  // registered so ready stays low while in reset
  assign tag_in.ready = not_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      not_full <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count_next;
      not_full <= (count_next != CNT_W'(TAG_DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      tag_mem[wr_ptr]  <= tag_in.tag;
      flag_mem[wr_ptr] <= tag_in.resp_flag;
      num_mem[wr_ptr]  <= tag_in.num;
    end
  end

  // head entry, shows the cycle after its push
  assign tag_out.valid     = (count != '0);
  assign tag_out.tag       = tag_mem[rd_ptr];
  assign tag_out.resp_flag = flag_mem[rd_ptr];
  assign tag_out.num       = num_mem[rd_ptr];

endmodule

// ==== rtl/read_tag_if.sv ====
/*
 * return tag channel
 * one pending read header with its beat count, valid/ready handshake
 */
interface read_tag_if;
  import noc_pkg::*;
  import dma_pkg::*;

  logic      valid;
  logic      ready;
  tag_t      tag;
  logic      resp_flag;
  beat_num_t num;

  modport src (
    output valid,
    output tag,
    output resp_flag,
    output num,
    input  ready
  );

  modport dst (
    input  valid,
    input  tag,
    input  resp_flag,
    input  num,
    output ready
  );

endinterface

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the read bridge testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f idma_noc_read_bridge.f \
  --top-module tb_idma_noc_read_bridge \
  -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

// ==== verif/read_bridge_asserts.sv ====
/*
 * handshake assertions on the read return sequencer
 */
module read_bridge_asserts #(
  parameter int DATA_WIDTH = 256
) (
  input logic                   clk,
  input logic                   rst_n,
  input noc_pkg::return_state_e state,
  input logic                   rd_data_ready,
  input logic                   data_out_valid,
  input logic [DATA_WIDTH-1:0]  data_out_flit,
  input logic                   data_out_last,
  input logic                   data_out_ready
);
  timeunit 1ns;
  timeprecision 100ps;
  import noc_pkg::*;

  int unsigned fail_count = 0;

  // flit held until the NoC takes it
  a_out_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_out_valid && !data_out_ready |=>
      data_out_valid && $stable(data_out_flit) && $stable(data_out_last)
  ) else begin
    $error("data_out flit dropped or changed while data_out_ready was low");
    fail_count++;
  end

  a_ready_in_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_data_ready |-> state == SEND_DATA
  ) else begin
    $error("rd_data_ready high outside SEND_DATA");
    fail_count++;
  end

  // header in flight, no data beat yet
  a_no_last_in_head: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == SEND_HEAD |-> !data_out_last
  ) else begin
    $error("data_out_last seen in SEND_HEAD");
    fail_count++;
  end

endmodule

bind read_return_seq read_bridge_asserts #(
  .DATA_WIDTH (DATA_WIDTH)
) u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .state          (state),
  .rd_data_ready  (rd_data_ready),
  .data_out_valid (data_out_valid),
  .data_out_flit  (data_out_flit),
  .data_out_last  (data_out_last),
  .data_out_ready (data_out_ready)
);

// ==== verif/tb_clk_gen.sv ====
/*
 * testbench clock and reset, 4 ns clock with a 16 cycle reset
 */
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== verif/tb_idma_noc_read_bridge.sv ====
/*
 * testbench for the NoC to iDMA read bridge
 * random requests, an iDMA responder model and a reference model of the returns
 */
module tb_idma_noc_read_bridge;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 256;
  localparam int TAG_DEPTH  = 16;
  localparam int RAND_REQS  = 120;
  localparam int BURST_REQS = 24;
  localparam int MAX_REQS   = 200;
  localparam int SEED       = 95359;

  logic                  clk;
  logic                  rst_n;
  logic                  ctrl_in_valid;
  logic [DATA_WIDTH-1:0] ctrl_in_flit;
  logic                  ctrl_in_ready;
  logic                  rd_req;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [31:0]           rd_num;
  logic                  rd_addr_ready;
  logic                  rd_data_valid;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  rd_data_ready;
  logic                  data_out_valid;
  logic [DATA_WIDTH-1:0] data_out_flit;
  logic                  data_out_last;
  logic                  data_out_ready;
  logic [ADDR_WIDTH-1:0] base_tab  [6];
  logic [ADDR_WIDTH-1:0] group_tab [6];
  logic                  dma_stall;

  // reference model queues
  logic [ADDR_WIDTH-1:0] exp_addr_q  [$];
  logic [31:0]           exp_num_q   [$];
  logic [DATA_WIDTH-1:0] exp_head_q  [$];
  int                    exp_beats_q [$];
  logic [DATA_WIDTH-1:0] exp_data_q  [$];
  int                    dma_jobs_q  [$];

  int err_count  = 0;
  int test_count = 0;
  int test_fail  = 0;
  int sent_count = 0;
  int done_count = 0;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  idma_noc_read_bridge #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .TAG_DEPTH  (TAG_DEPTH)
  ) u_dut (
    .*,
    .base_addr_0       (base_tab[0]),
    .base_addr_1       (base_tab[1]),
    .base_addr_2       (base_tab[2]),
    .base_addr_3       (base_tab[3]),
    .base_addr_4       (base_tab[4]),
    .base_addr_5       (base_tab[5]),
    .group_base_addr_0 (group_tab[0]),
    .group_base_addr_1 (group_tab[1]),
    .group_base_addr_2 (group_tab[2]),
    .group_base_addr_3 (group_tab[3]),
    .group_base_addr_4 (group_tab[4]),
    .group_base_addr_5 (group_tab[5])
  );

  task automatic report_mismatch(string name, logic [DATA_WIDTH-1:0] got,
                                 logic [DATA_WIDTH-1:0] exp);
    $display("[ERROR] %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    err_count++;
  endtask

  task automatic report_fault(string what);
    $display("error at %0t ns: %s", $time, what);
    err_count++;
  endtask

  task automatic finish_test(string name, int errs_before);
    test_count++;
    if (err_count != errs_before) begin
      test_fail++;
      $display("test %s: failed with %0d errors", name, err_count - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic check_idle_outputs();
    if (rd_req !== 1'b0) begin
      report_mismatch("rd_req", DATA_WIDTH'(rd_req), '0);
    end
    if (rd_data_ready !== 1'b0) begin
      report_mismatch("rd_data_ready", DATA_WIDTH'(rd_data_ready), '0);
    end
    if (data_out_valid !== 1'b0) begin
      report_mismatch("data_out_valid", DATA_WIDTH'(data_out_valid), '0);
    end
  endtask

  // two slots per mesh row, column pairs 0/2 and 1/3 share a slot
  function automatic logic [ADDR_WIDTH-1:0] model_base(logic [3:0] node, logic grp);
    int slot;
    if (node > 4'd11) return '0;
    slot = int'(node[3:2]) * 2 + int'(node[0]);
    return grp ? group_tab[slot] : base_tab[slot];
  endfunction

  task automatic send_request();
    logic [DATA_WIDTH-1:0] flit;
    logic [DATA_WIDTH-1:0] head;
    logic [3:0]            node;
    logic [11:0]           tag;
    logic [24:0]           offset;
    logic [12:0]           num;
    logic                  grp;
    logic                  flag;
    for (int i = 0; i < 8; i++) begin
      flit[i*32 +: 32] = $urandom;
    end
    node   = 4'($urandom % 16);
    tag    = {8'($urandom), node};
    offset = 25'($urandom);
    num    = 13'($urandom_range(8, 1));
    grp    = 1'($urandom);
    flag   = 1'($urandom);
    flit[18:7]  = tag;
    flit[5]     = flag;
    flit[43:19] = offset;
    flit[81:69] = num;
    flit[254]   = grp;
    head     = '0;
    head[11:0] = tag;
    head[12] = 1'b1;
    head[13] = flag;
    ctrl_in_valid = 1'b1;
    ctrl_in_flit  = flit;
    // ready seen mid-cycle, transfer at the next edge
    do begin
      @(negedge clk);
    end while (ctrl_in_ready !== 1'b1);
    exp_addr_q.push_back(model_base(node, grp) + {offset[23:0], 8'h00});
    exp_num_q.push_back(32'(num) * 8);
    exp_head_q.push_back(head);
    exp_beats_q.push_back(int'(num));
    sent_count++;
    @(posedge clk);
    #1;
    ctrl_in_valid = 1'b0;
  endtask

  // ==============================
  // iDMA request side
  // ==============================
  initial begin : addr_side
    logic                  held;
    logic [ADDR_WIDTH-1:0] held_addr;
    logic [ADDR_WIDTH-1:0] a;
    logic [31:0]           n;
    held = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rd_addr_ready = rst_n && ($urandom % 4 != 0);
      @(negedge clk);
      if (held && (rd_req !== 1'b1 || rd_addr !== held_addr)) begin
        report_fault("rd_req dropped or rd_addr changed before rd_addr_ready");
      end
      held      = rd_req && !rd_addr_ready;
      held_addr = rd_addr;
      if (rd_req && rd_addr_ready) begin
        if (exp_addr_q.size() == 0) begin
          report_fault("rd_req issued with no request pending");
        end else begin
          a = exp_addr_q.pop_front();
          n = exp_num_q.pop_front();
          if (rd_addr !== a) report_mismatch("rd_addr", DATA_WIDTH'(rd_addr), DATA_WIDTH'(a));
          if (rd_num !== n) report_mismatch("rd_num", DATA_WIDTH'(rd_num), DATA_WIDTH'(n));
          dma_jobs_q.push_back(int'(n >> 3));
        end
      end
    end
  end

  // beats returned in request order, random gaps
  initial begin : data_side
    int                    beats;
    logic [DATA_WIDTH-1:0] beat;
    forever begin
      @(posedge clk);
      #1;
      if (dma_jobs_q.size() != 0 && !dma_stall) begin
        beats = dma_jobs_q.pop_front();
        for (int b = 0; b < beats; b++) begin
          repeat ($urandom % 3) begin
            @(posedge clk);
            #1;
          end
          for (int i = 0; i < 8; i++) begin
            beat[i*32 +: 32] = $urandom;
          end
          rd_data_valid = 1'b1;
          rd_data       = beat;
          do begin
            @(negedge clk);
          end while (rd_data_ready !== 1'b1);
          exp_data_q.push_back(beat);
          @(posedge clk);
          #1;
          rd_data_valid = 1'b0;
        end
      end
    end
  end

  // ==============================
  // NoC data channel checker
  // ==============================
  initial begin : out_side
    int                    left;
    logic [DATA_WIDTH-1:0] exp;
    left = 0;
    forever begin
      @(posedge clk);
      #1;
      data_out_ready = rst_n && ($urandom % 4 != 0);
      @(negedge clk);
      if (data_out_valid && data_out_ready) begin
        if (left == 0) begin
          if (exp_head_q.size() == 0) begin
            report_fault("flit on data_out with no read pending");
          end else begin
            exp  = exp_head_q.pop_front();
            left = exp_beats_q.pop_front();
            if (data_out_flit !== exp) report_mismatch("data_out_flit", data_out_flit, exp);
            if (data_out_last !== 1'b0) begin
              report_mismatch("data_out_last", DATA_WIDTH'(data_out_last), '0);
            end
          end
        end else begin
          if (exp_data_q.size() == 0) begin
            report_fault("data beat on data_out before the iDMA returned it");
          end else begin
            exp = exp_data_q.pop_front();
            if (data_out_flit !== exp) report_mismatch("data_out_flit", data_out_flit, exp);
            if (data_out_last !== (left == 1)) begin
              report_mismatch("data_out_last", DATA_WIDTH'(data_out_last),
                              DATA_WIDTH'(left == 1));
            end
          end
          left--;
          if (left == 0) done_count++;
        end
      end
    end
  end

  initial begin : watchdog
    #(MAX_REQS * 40 * 4);
    $display("timeout: reads still pending after %0d ns", MAX_REQS * 40 * 4);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    int errs;
    int burst_base;
    void'($urandom(SEED));
    ctrl_in_valid  = 1'b0;
    ctrl_in_flit   = '0;
    rd_addr_ready  = 1'b0;
    rd_data_valid  = 1'b0;
    rd_data        = '0;
    data_out_ready = 1'b0;
    dma_stall      = 1'b0;
    for (int i = 0; i < 6; i++) begin
      base_tab[i]  = $urandom;
      group_tab[i] = $urandom;
    end

    // outputs quiet during and right after reset
    errs = err_count;
    do begin
      @(negedge clk);
      if (ctrl_in_ready !== 1'b0) begin
        report_mismatch("ctrl_in_ready", DATA_WIDTH'(ctrl_in_ready), '0);
      end
      check_idle_outputs();
    end while (rst_n !== 1'b1);
    repeat (3) begin
      @(negedge clk);
      check_idle_outputs();
    end
    finish_test("reset_values", errs);

    // random traffic with random back-pressure
    errs = err_count;
    @(posedge clk);
    #1;
    repeat (RAND_REQS) begin
      send_request();
      repeat ($urandom % 3) begin
        @(posedge clk);
        #1;
      end
    end
    wait (done_count == sent_count);
    if (exp_data_q.size() != 0 || exp_addr_q.size() != 0 || dma_jobs_q.size() != 0) begin
      report_fault("reference queues not empty after all reads returned");
    end
    finish_test("random_traffic", errs);

    // burst with the iDMA data side stalled
    @(posedge clk);
    #1;
    errs       = err_count;
    burst_base = sent_count;
    dma_stall  = 1'b1;
    fork
      begin
        repeat (BURST_REQS) send_request();
      end
      begin
        repeat (200) @(posedge clk);
        // one tag sits in the sequencer, the rest fill the tag buffer
        if (sent_count - burst_base != TAG_DEPTH + 1) begin
          report_mismatch("accepted requests", DATA_WIDTH'(sent_count - burst_base),
                          DATA_WIDTH'(TAG_DEPTH + 1));
        end
        dma_stall = 1'b0;
      end
    join
    wait (done_count == sent_count);
    finish_test("burst_stall", errs);

    if (u_dut.u_return_seq.u_asserts.fail_count != 0) begin
      report_fault("handshake assertions failed in the return sequencer");
    end
    $display("tests run: %0d, tests failed: %0d, errors: %0d", test_count, test_fail,
             err_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
